// ==== logic/ik_macros.svh ====
// ik macros: matrix size, operand widths and the APB register map of the JJT engine
`ifndef IK_MACROS_SVH
`define IK_MACROS_SVH

// matrix size and datapath widths
`define IK_DOF 6
`define IK_ELEM_W 12
`define IK_ACC_W 32
`define IK_DAMP_W 16
`define IK_ADDR_W 12

// register map, byte offsets
`define IK_CTRL_ADDR 'h000
`define IK_STATUS_ADDR 'h004
`define IK_DAMP_ADDR 'h008
// entry (r, c) at base + 4 * (r * IK_DOF + c)
`define IK_JAC_BASE 'h100
`define IK_RES_BASE 'h200

`endif

// ==== logic/ik_pkg.sv ====
// ik package: operand, accumulator, index and matrix types for the JJT datapath
`include "ik_macros.svh"

package ik_pkg;

	// index width, kept at one bit or more
	localparam int IDX_W = (`IK_DOF > 1) ? $clog2(`IK_DOF) : 1;

	// signed jacobian entry
	typedef logic signed [`IK_ELEM_W-1:0] elem_t;

	// signed accumulator and result entry
	typedef logic signed [`IK_ACC_W-1:0] acc_t;

	// lambda is never negative
	typedef logic [`IK_DAMP_W-1:0] damp_t;

	// row or column index
	typedef logic [IDX_W-1:0] idx_t;

	// full matrices, indexed [row][col]
	typedef elem_t jac_mat_t [`IK_DOF][`IK_DOF];
	typedef acc_t res_mat_t [`IK_DOF][`IK_DOF];

endpackage

// ==== logic/mac_if.sv ====
// mac lane interface: operand beats into one lane and finished row entries out
`timescale 1ns/1ps

interface mac_if;
	import ik_pkg::*;

	// issue side, one beat per cycle while valid
	logic issue_valid;
	logic issue_first;
	logic issue_last;
	idx_t issue_col;
	// a is the lane's own row entry, b the broadcast one
	elem_t a;
	elem_t b;

	// result side, one completed dot product
	logic res_valid;
	idx_t res_col;
	acc_t res_data;

	modport feed (
		output issue_valid,
		output issue_first,
		output issue_last,
		output issue_col,
		output a,
		output b
	);

	modport lane (
		input issue_valid,
		input issue_first,
		input issue_last,
		input issue_col,
		input a,
		input b,
		output res_valid,
		output res_col,
		output res_data
	);

	// no back-pressure, the collector takes every result
	modport drain (
		input res_valid,
		input res_col,
		input res_data
	);

endinterface

// ==== logic/jjt_apb_regs.sv ====
// jjt register block: APB slave for control, status, damping, jacobian and result reads
`timescale 1ns/1ps
`include "ik_macros.svh"

module jjt_apb_regs (
	input logic i,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`IK_ADDR_W-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output ik_pkg::jac_mat_t jac,
	output ik_pkg::damp_t damp,
	output logic start,
	input ik_pkg::res_mat_t result,
	input logic finished,
	output logic done
);
	import ik_pkg::*;

	localparam int ADDR_W = `IK_ADDR_W;

	logic access;
	logic is_ctrl;
	logic is_status;
	logic is_damp;
	logic jac_hit;
	logic res_hit;
	logic err;
	logic wr_ok;
	logic busy;
	idx_t sel_r;
	idx_t sel_c;

	// every access finishes in its access phase
	assign pready = 1'b1;
	assign access = psel && penable;

	assign is_ctrl = (paddr == ADDR_W'(`IK_CTRL_ADDR));
	assign is_status = (paddr == ADDR_W'(`IK_STATUS_ADDR));
	assign is_damp = (paddr == ADDR_W'(`IK_DAMP_ADDR));

	// matrix entry decode, shared row and column select for both banks
	always_comb begin
		jac_hit = 1'b0;
		res_hit = 1'b0;
		sel_r = '0;
		sel_c = '0;
		for (int r = 0; r < `IK_DOF; r++) begin
			for (int c = 0; c < `IK_DOF; c++) begin
				if (paddr == ADDR_W'(`IK_JAC_BASE + 4 * (r * `IK_DOF + c))) begin
					jac_hit = 1'b1;
					sel_r = idx_t'(r);
					sel_c = idx_t'(c);
				end
				if (paddr == ADDR_W'(`IK_RES_BASE + 4 * (r * `IK_DOF + c))) begin
					res_hit = 1'b1;
					sel_r = idx_t'(r);
					sel_c = idx_t'(c);
				end
			end
		end
	end

	// illegal access check
	always_comb begin
		err = 1'b0;
		if (!(is_ctrl || is_status || is_damp || jac_hit || res_hit)) begin
			err = 1'b1;
		end else if (pwrite) begin
			if (is_status || res_hit)
				err = 1'b1;
			else if ((is_damp || jac_hit) && busy)
				err = 1'b1;
			// second start while a matrix is in flight
			else if (is_ctrl && pwdata[0] && busy)
				err = 1'b1;
		end
	end

	assign pslverr = access && err;
	assign wr_ok = access && pwrite && !err;

	// read mux, control reads as zero
	always_comb begin
		prdata = '0;
		if (is_status)
			prdata = {30'b0, done, busy};
		else if (is_damp)
			prdata = 32'(damp);
		else if (jac_hit)
			prdata = 32'(jac[sel_r][sel_c]);
		else if (res_hit)
			prdata = 32'(result[sel_r][sel_c]);
	end

	always_ff @(posedge i) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			start <= 1'b0;
			damp <= '0;
			for (int r = 0; r < `IK_DOF; r++) begin
				for (int c = 0; c < `IK_DOF; c++) begin
					jac[r][c] <= '0;
				end
			end
		end else begin
			start <= 1'b0;
			if (wr_ok) begin
				if (is_ctrl && pwdata[0]) begin
					busy <= 1'b1;
					done <= 1'b0;
					start <= 1'b1;
				end
				if (is_damp)
					damp <= damp_t'(pwdata);
				if (jac_hit)
					jac[sel_r][sel_c] <= elem_t'(pwdata);
			end
			// collector has stored the last column
			if (finished) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

endmodule

// ==== logic/jjt_sequencer.sv ====
// jjt sequencer: steps column and term indices and broadcasts operand beats to all lanes
`timescale 1ns/1ps
`include "ik_macros.svh"

module jjt_sequencer (
	input logic i,
	input logic rst,
	input logic start,
	input ik_pkg::jac_mat_t jac,
	mac_if.feed lanes [`IK_DOF]
);
	import ik_pkg::*;

	localparam idx_t LAST_IDX = idx_t'(`IK_DOF - 1);

	logic run;
	idx_t col;
	idx_t term;
	logic first_term;
	logic last_term;

	assign first_term = (term == '0);
	assign last_term = (term == LAST_IDX);

	// column j outer, term m inner, one beat per cycle
	always_ff @(posedge i) begin
		if (rst) begin
			run <= 1'b0;
			col <= '0;
			term <= '0;
		end else if (start) begin
			run <= 1'b1;
			col <= '0;
			term <= '0;
		end else if (run) begin
			if (last_term) begin
				term <= '0;
				if (col == LAST_IDX) begin
					run <= 1'b0;
					col <= '0;
				end else begin
					col <= col + 1'b1;
				end
			end else begin
				term <= term + 1'b1;
			end
		end
	end

	// lane k gets J(k, m) on a and J(j, m) on b
	for (genvar k = 0; k < `IK_DOF; k++) begin : g_feed
		assign lanes[k].issue_valid = run;
		assign lanes[k].issue_first = first_term;
		assign lanes[k].issue_last = last_term;
		assign lanes[k].issue_col = col;
		assign lanes[k].a = jac[k][term];
		assign lanes[k].b = jac[col][term];
	end

endmodule

// ==== logic/mac_lane.sv ====
// mac lane: multiply-accumulate of one jacobian row against each column in turn
`timescale 1ns/1ps

module mac_lane (
	input logic i,
	input logic rst,
	mac_if.lane port
);
	import ik_pkg::*;

	acc_t acc;
	acc_t prod;
	acc_t sum;

	// operands widened before the multiply so the product is exact
	assign prod = acc_t'(port.a) * acc_t'(port.b);
	assign sum = port.issue_first ? prod : acc + prod;

	// running sum, restarted on the first term of each column
	always_ff @(posedge i) begin
		if (port.issue_valid)
			acc <= sum;
	end

	always_ff @(posedge i) begin
		if (rst)
			port.res_valid <= 1'b0;
		else
			port.res_valid <= port.issue_valid && port.issue_last;
	end

	// completed dot product and its column
	always_ff @(posedge i) begin
		if (port.issue_valid && port.issue_last) begin
			port.res_data <= sum;
			port.res_col <= port.issue_col;
		end
	end

endmodule

// ==== logic/jjt_collector.sv ====
// jjt collector: stores lane results, adds lambda on the diagonal, flags completion
`timescale 1ns/1ps
`include "ik_macros.svh"

module jjt_collector (
	input logic i,
	input logic rst,
	input ik_pkg::damp_t damp,
	mac_if.drain lanes [`IK_DOF],
	output ik_pkg::res_mat_t result,
	output logic finished
);
	import ik_pkg::*;

	localparam idx_t LAST_IDX = idx_t'(`IK_DOF - 1);

	logic res_v [`IK_DOF];
	idx_t res_c [`IK_DOF];
	acc_t res_d [`IK_DOF];
	acc_t bias;

	// flatten the lane results so one process can store them
	for (genvar k = 0; k < `IK_DOF; k++) begin : g_drain
		assign res_v[k] = lanes[k].res_valid;
		assign res_c[k] = lanes[k].res_col;
		assign res_d[k] = lanes[k].res_data;
	end

	assign bias = acc_t'(damp);

	always_ff @(posedge i) begin
		if (rst) begin
			finished <= 1'b0;
			for (int r = 0; r < `IK_DOF; r++) begin
				for (int c = 0; c < `IK_DOF; c++) begin
					result[r][c] <= '0;
				end
			end
		end else begin
			// lane k owns row k
			for (int k = 0; k < `IK_DOF; k++) begin
				if (res_v[k]) begin
					if (res_c[k] == idx_t'(k))
						result[k][res_c[k]] <= res_d[k] + bias;
					else
						result[k][res_c[k]] <= res_d[k];
				end
			end
			// all lanes run in lockstep, lane 0 marks the last column
			finished <= res_v[0] && (res_c[0] == LAST_IDX);
		end
	end

endmodule

// ==== logic/jjt_top.sv ====
// jjt top: APB-mapped engine forming J * J^T plus lambda on the diagonal
`timescale 1ns/1ps
`include "ik_macros.svh"

module jjt_top (
	input logic i,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`IK_ADDR_W-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic done
);
	import ik_pkg::*;

	jac_mat_t jac;
	res_mat_t result;
	damp_t damp;
	logic start;
	logic finished;

	// one interface per lane
	mac_if lane_if [`IK_DOF] ();

	jjt_apb_regs i_regs (
		.i(i),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.jac(jac),
		.damp(damp),
		.start(start),
		.result(result),
		.finished(finished),
		.done(done)
	);

	jjt_sequencer i_seq (
		.i(i),
		.rst(rst),
		.start(start),
		.jac(jac),
		.lanes(lane_if)
	);

	// lane k computes row k
	for (genvar k = 0; k < `IK_DOF; k++) begin : g_lane
		mac_lane i_lane (
			.i(i),
			.rst(rst),
			.port(lane_if[k])
		);
	end

	jjt_collector i_coll (
		.i(i),
		.rst(rst),
		.damp(damp),
		.lanes(lane_if),
		.result(result),
		.finished(finished)
	);

endmodule

// ==== dv/jjt_asserts.sv ====
// jjt checker: APB protocol, completion latency and done/status agreement on jjt_top
`timescale 1ns/1ps
`include "ik_macros.svh"

module jjt_asserts (
	input logic i,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`IK_ADDR_W-1:0] paddr,
	input logic [31:0] pwdata,
	input logic [31:0] prdata,
	input logic pready,
	input logic pslverr,
	input logic done
);
	localparam int DONE_LAT = `IK_DOF * `IK_DOF + 4;

	int unsigned fail_count = 0;
	logic access;
	logic start_ok;
	logic status_rd;

	assign access = psel && penable;
	assign start_ok = access && pwrite && !pslverr && pwdata[0]
		&& (paddr == `IK_ADDR_W'(`IK_CTRL_ADDR));
	assign status_rd = access && !pwrite && (paddr == `IK_ADDR_W'(`IK_STATUS_ADDR));

	ready_high: assert property (@(posedge i) disable iff (rst) pready)
		else begin $error("pready went low"); fail_count++; end

	err_in_access: assert property (@(posedge i) disable iff (rst) pslverr |-> access)
		else begin $error("pslverr outside an access phase"); fail_count++; end

	// fixed pipeline depth from the accepted start write
	done_in_time: assert property (@(posedge i) disable iff (rst)
		start_ok |-> ##[1:DONE_LAT] done)
		else begin $error("done late after start"); fail_count++; end

	done_matches_status: assert property (@(posedge i) disable iff (rst)
		status_rd |-> (prdata[1] == done))
		else begin $error("done output differs from status bit 1"); fail_count++; end

endmodule

bind jjt_top jjt_asserts i_asserts (.*);

// ==== dv/jjt_tb.sv ====
// jjt testbench: drives the engine over APB and checks every read against an integer model
`timescale 1ns/1ps
`include "ik_macros.svh"

module jjt_tb;
	localparam int N = `IK_DOF;
	localparam int MAX_RUNS = 20;
	// per run: operand writes, readback, result reads and polls, two cycles each
	localparam int APB_CYCLES = 2 * (3 * N * N + 40);
	localparam int WATCHDOG_CYCLES = MAX_RUNS * (N * N + 50 + APB_CYCLES) + 100;

	logic i;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`IK_ADDR_W-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic done;
	logic [31:0] rng;
	int jm [N][N];
	int lam;

	jjt_top i_jjt_top (.*);

	initial i = 1'b0;
	always #10 i = ~i;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic int jac_addr(input int r, input int c);
		return `IK_JAC_BASE + 4 * (r * N + c);
	endfunction

	function automatic int res_addr(input int r, input int c);
		return `IK_RES_BASE + 4 * (r * N + c);
	endfunction

	// row r of J dotted with row c, lambda on the diagonal
	function automatic int model_entry(input int r, input int c);
		int sum;
		sum = (r == c) ? lam : 0;
		for (int m = 0; m < N; m++)
			sum += jm[r][m] * jm[c][m];
		return sum;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endtask

	// one setup and one access cycle, called 1 ns after a rising edge
	task automatic apb_xfer(input logic wr, input int addr, input logic [31:0] data,
		output logic [31:0] rd, output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = `IK_ADDR_W'(addr);
		pwdata = data;
		@(posedge i);
		#1;
		penable = 1'b1;
		@(negedge i);
		rd = prdata;
		err = pslverr;
		@(posedge i);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input int addr, input logic [31:0] data, input logic want_err);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b1, addr, data, rd, err);
		assert (err == want_err) else abort_run($sformatf(
			"error at %0t ns: pslverr %0b on write to %h", $time, err, addr));
	endtask

	task automatic read_check(input int addr, input logic [31:0] want, input string what);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b0, addr, 32'h0, rd, err);
		assert (!err && rd == want) else abort_run($sformatf(
			"error at %0t ns: %s at %h read %h pslverr %0b, expected %h",
			$time, what, addr, rd, err, want));
	endtask

	task automatic read_reject(input int addr);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b0, addr, 32'h0, rd, err);
		assert (err) else abort_run($sformatf(
			"error at %0t ns: no pslverr on read of unmapped %h", $time, addr));
	endtask

	// mode 0 random, 1 extreme values, 2 identity, 3 zero
	task automatic fill_operands(input int mode);
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				rng = xorshift(rng);
				case (mode)
					1: jm[r][c] = ((r + c) % 3 == 0) ? 2047 : -2048;
					2: jm[r][c] = (r == c) ? 1 : 0;
					3: jm[r][c] = 0;
					default: jm[r][c] = $signed(rng[11:0]);
				endcase
			end
		end
		rng = xorshift(rng);
		lam = (mode == 1) ? 65535 : int'(rng[15:0]);
	endtask

	task automatic run_case(input int mode, input bit readback, input bit poke);
		logic [31:0] rd;
		logic err;
		fill_operands(mode);
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				apb_write(jac_addr(r, c), 32'(jm[r][c]), 1'b0);
		apb_write(`IK_DAMP_ADDR, 32'(lam), 1'b0);
		if (readback) begin
			for (int r = 0; r < N; r++)
				for (int c = 0; c < N; c++)
					read_check(jac_addr(r, c), 32'(jm[r][c]), "jacobian readback");
			read_check(`IK_DAMP_ADDR, 32'(lam), "damping readback");
		end
		apb_write(`IK_CTRL_ADDR, 32'h1, 1'b0);
		read_check(`IK_STATUS_ADDR, 32'h1, "status while busy");
		// all rejected while the matrix is in flight
		if (poke) begin
			apb_write(jac_addr(0, 0), ~32'(jm[0][0]), 1'b1);
			apb_write(`IK_DAMP_ADDR, 32'(lam) ^ 32'h5a5a, 1'b1);
			apb_write(`IK_CTRL_ADDR, 32'h1, 1'b1);
		end
		rd = 32'h0;
		while (!rd[1])
			apb_xfer(1'b0, `IK_STATUS_ADDR, 32'h0, rd, err);
		assert (rd == 32'h2 && done) else abort_run($sformatf(
			"error at %0t ns: status %h done %0b after completion", $time, rd, done));
		if (poke) begin
			read_check(jac_addr(0, 0), 32'(jm[0][0]), "jacobian after busy write");
			read_check(`IK_DAMP_ADDR, 32'(lam), "damping after busy write");
		end
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				read_check(res_addr(r, c), 32'(model_entry(r, c)), "result entry");
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i);
		abort_run($sformatf("timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES));
	end

	always @(posedge i) begin
		if (i_jjt_top.i_asserts.fail_count != 0)
			abort_run("a bound protocol or completion assertion failed");
	end

	initial begin
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rst = 1'b1;
		rng = 32'h87d7;
		repeat (10) @(posedge i);
		#1;
		rst = 1'b0;
		assert (!done) else abort_run($sformatf("error at %0t ns: done high after reset", $time));
		read_check(`IK_STATUS_ADDR, 32'h0, "status after reset");
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				read_check(res_addr(r, c), 32'h0, "result after reset");
		run_case(1, 1'b1, 1'b0);
		run_case(2, 1'b0, 1'b0);
		run_case(3, 1'b0, 1'b0);
		run_case(0, 1'b1, 1'b1);
		repeat (4) run_case(0, 1'b0, 1'b0);
		// unmapped, unaligned and read-only targets
		read_reject('h00c);
		read_reject('h0fc);
		read_reject('h102);
		read_reject(jac_addr(N - 1, N - 1) + 4);
		read_reject(res_addr(N - 1, N - 1) + 4);
		apb_write('h00c, 32'h1234, 1'b1);
		apb_write(`IK_STATUS_ADDR, 32'h3, 1'b1);
		apb_write(res_addr(1, 2), 32'hdead_beef, 1'b1);
		read_check(res_addr(1, 2), 32'(model_entry(1, 2)), "result after rejected write");
		read_check(`IK_STATUS_ADDR, 32'h2, "status after rejected write");
		@(posedge i);
		if (i_jjt_top.i_asserts.fail_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			abort_run("a bound assertion failed near the end of the run");
		end
	end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/ik_pkg.sv
logic/mac_if.sv
logic/jjt_apb_regs.sv
logic/jjt_sequencer.sv
logic/mac_lane.sv
logic/jjt_collector.sv
logic/jjt_top.sv
dv/jjt_asserts.sv
dv/jjt_tb.sv
